//--- Makefile
VERILATOR ?= verilator
TOP       ?= bubsys_video_tb
FILELIST  ?= bubsys_video.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- bubsys_video.f
verilog/bubsys_video_pkg.sv
verilog/clock_enable_gen.sv
verilog/video_counter.sv
verilog/vram_access_ctrl.sv
verilog/vram_bank.sv
verilog/tile_fetch.sv
verilog/cpu_read_mux.sv
verilog/bubsys_video.sv
verification/bubsys_video_tb.sv

//--- verification/bubsys_video_tb.sv
module bubsys_video_tb;

    import bubsys_video_pkg::*;

    localparam int CLK_HALF     = 20;                   // 40 unit MCLK
    localparam int RESET_CYCLES = 16;
    localparam int HOLD_PIXELS  = 16;                   // Select held per CPU access
    localparam int LINE_CYCLES  = H_TOTAL * 6;          // Six MCLK per pixel
    localparam int FRAME_CYCLES = LINE_CYCLES * V_TOTAL;
    localparam int TILE_LINES   = 16;                   // Lines checked per vflip value
    localparam int NUM_ROWS     = 18;

    // Row operations
    localparam logic [1:0] OP_WRITE = 2'd0;
    localparam logic [1:0] OP_READ  = 2'd1;
    localparam logic [1:0] OP_FILL  = 2'd2;             // Same data at every address
    localparam logic [1:0] OP_TILE  = 2'd3;             // Fetch check over several lines

    localparam logic [1:0] BANK_NONE = 2'd0;            // Neither select low
    localparam logic [1:0] BANK_CODE = 2'd1;            // VCS1
    localparam logic [1:0] BANK_ATTR = 2'd2;            // VCS2

    // Enable lows per 18M tick as {9MP, 9MN, 6MP, 6MN}
    localparam logic [3:0] CEN_ORDER [6] = '{
        4'b0110,                                        // 9MP + 6MN
        4'b1001,                                        // 9MN + 6MP
        4'b0111,                                        // 9MP
        4'b1010,                                        // 9MN + 6MN
        4'b0101,                                        // 9MP + 6MP
        4'b1011                                         // 9MN
    };

    typedef struct packed {
        logic [1:0]  op;
        logic [1:0]  bank;
        logic [14:0] addr;
        logic [15:0] data;
        logic [1:0]  strobe_n;                          // {uds_n, lds_n}
        logic [15:0] expect_val;                        // Read rows only
    } stim_row_t;

    logic        clk;
    logic        rst;
    logic        cen18_n;
    logic [14:0] cpu_addr;
    logic [15:0] cpu_din;
    logic        cpu_rw;
    logic        cpu_uds_n;
    logic        cpu_lds_n;
    logic        vcs1_n;
    logic        vcs2_n;

    logic        cen9p_n;
    logic        cen9n_n;
    logic        cen6p_n;
    logic        cen6n_n;
    logic [15:0] cpu_dout;
    logic        hblank_n;
    logic        vblank_n;
    logic        vsync_n;
    logic        csync_n;
    tile_fetch_t tile_out;

    stim_row_t   stim [NUM_ROWS];
    logic [15:0] fill_word;                             // Word now in all of bank 1
    logic [7:0]  fill_attr;                             // Byte now in all of bank 2
    int          error_count;

    bubsys_video bubsys_video_inst
    (
        .i_EMU_MCLK         (clk),
        .i_rst              (rst),
        .i_EMU_CLK18MNCEN_n (cen18_n),
        .o_EMU_CLK9MPCEN_n  (cen9p_n),
        .o_EMU_CLK9MNCEN_n  (cen9n_n),
        .o_EMU_CLK6MPCEN_n  (cen6p_n),
        .o_EMU_CLK6MNCEN_n  (cen6n_n),
        .i_CPU_ADDR         (cpu_addr),
        .i_CPU_DIN          (cpu_din),
        .o_CPU_DOUT         (cpu_dout),
        .i_CPU_RW           (cpu_rw),
        .i_CPU_UDS_n        (cpu_uds_n),
        .i_CPU_LDS_n        (cpu_lds_n),
        .i_VCS1_n           (vcs1_n),
        .i_VCS2_n           (vcs2_n),
        .o_HBLANK_n         (hblank_n),
        .o_VBLANK_n         (vblank_n),
        .o_VSYNC_n          (vsync_n),
        .o_CSYNC_n          (csync_n),
        .o_tile_fetch       (tile_out)
    );

    //////////////////////////////////////////////////
    // Clock and 18M enable

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #CLK_HALF clk = ~clk;
        end
    end

    // Low on every second MCLK
    always @(negedge clk)
    begin
        cen18_n <= ~cen18_n;
    end

    //////////////////////////////////////////////////
    // Reporting

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        assert (got == exp)
        else
        begin
            error_count++;
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: gave up waiting for %s", what);
        abort_run();
    endtask

    //////////////////////////////////////////////////
    // Waits sample at the rising edge

    // Counts 6MP enables (one per pixel)
    task automatic wait_pixels(input int n, input string what);
        int seen;
        int guard;
        seen  = 0;
        guard = 0;
        while (seen < n)
        begin
            @(posedge clk);
            if (!cen6p_n)
                seen++;
            guard++;
            if (guard > n * 8 + 16)
                report_timeout(what);
        end
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        int   guard;
        prev  = vsync_n;
        guard = 0;
        @(posedge clk);
        while (!(prev && !vsync_n))
        begin
            prev = vsync_n;
            guard++;
            if (guard > FRAME_CYCLES + LINE_CYCLES)
                report_timeout("falling edge of o_VSYNC_n");
            @(posedge clk);
        end
    endtask

    // New line starts where hblank_n goes high
    task automatic wait_hblank_rise();
        logic prev;
        int   guard;
        prev  = hblank_n;
        guard = 0;
        @(posedge clk);
        while (!(!prev && hblank_n))
        begin
            prev = hblank_n;
            guard++;
            if (guard > LINE_CYCLES * 2)
                report_timeout("rising edge of o_HBLANK_n");
            @(posedge clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Clock enable order

    task automatic enable_sequence_test();
        logic [3:0] got;
        int         step;
        int         seen;
        int         guard;
        guard = 0;
        got   = 4'hF;
        // Lock onto the first 9MP+6MN tick
        while (cen18_n || got != CEN_ORDER[0])
        begin
            @(posedge clk);
            got = {cen9p_n, cen9n_n, cen6p_n, cen6n_n};
            guard++;
            if (guard > 64)
                report_timeout("first 9MP+6MN enable");
        end
        step = 1;
        seen = 1;
        while (seen < 60)
        begin
            @(posedge clk);
            got = {cen9p_n, cen9n_n, cen6p_n, cen6n_n};
            if (cen18_n)
            begin
                expect_equal(32'(got), 32'hF, "enables outside an 18M tick");
            end
            else
            begin
                expect_equal(32'(got), 32'(CEN_ORDER[step]), $sformatf("enables on tick %0d", seen));
                step = (step + 1) % 6;
                seen++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // One frame of blanking and sync from vsync fall to vsync fall

    task automatic frame_timing_test();
        int   lines;
        int   vblank_lines;
        int   vsync_lines;
        int   pixels;
        int   guard;
        logic prev_hblank;
        logic prev_vsync;
        logic done;
        wait_vsync_fall();
        lines        = 0;
        vblank_lines = 0;
        vsync_lines  = 0;
        pixels       = 0;
        guard        = 0;
        done         = 1'b0;
        prev_hblank  = hblank_n;
        prev_vsync   = vsync_n;
        while (!done)
        begin
            @(posedge clk);
            guard++;
            if (guard > FRAME_CYCLES + LINE_CYCLES)
                report_timeout("end of the video frame");
            if (!cen6p_n && hblank_n)
                pixels++;                               // Visible pixel closes here
            if (!vsync_n)
                expect_equal(32'(csync_n), 32'h0, "o_CSYNC_n in vertical sync");
            if (prev_hblank && !hblank_n)               // End of a line
            begin
                expect_equal(pixels, H_ACTIVE, "visible pixels in a line");
                pixels = 0;
                lines++;
                if (!vblank_n)
                    vblank_lines++;
                if (!vsync_n)
                    vsync_lines++;
            end
            if (prev_vsync && !vsync_n)
                done = 1'b1;
            prev_hblank = hblank_n;
            prev_vsync  = vsync_n;
        end
        expect_equal(lines, V_TOTAL, "lines per frame");
        expect_equal(vblank_lines, V_TOTAL - V_ACTIVE, "lines in vertical blank");
        expect_equal(vsync_lines, VSYNC_LEN, "lines in vertical sync");
    endtask

    //////////////////////////////////////////////////
    // CPU side

    // Select held for a fixed pixel count, then one idle pixel
    task automatic cpu_access(input stim_row_t row, output logic [15:0] rdata);
        @(negedge clk);
        cpu_addr  = row.addr;
        cpu_din   = row.data;
        cpu_rw    = (row.op == OP_READ);
        cpu_uds_n = row.strobe_n[1];
        cpu_lds_n = row.strobe_n[0];
        vcs1_n    = (row.bank != BANK_CODE);
        vcs2_n    = (row.bank != BANK_ATTR);
        wait_pixels(HOLD_PIXELS, "end of the CPU access hold");
        rdata = cpu_dout;                               // Select still low here
        @(negedge clk);
        vcs1_n    = 1'b1;
        vcs2_n    = 1'b1;
        cpu_rw    = 1'b1;
        cpu_uds_n = 1'b1;
        cpu_lds_n = 1'b1;
        wait_pixels(1, "idle pixel after a CPU access");
    endtask

    task automatic fill_bank(input stim_row_t row);
        stim_row_t   one;
        logic [15:0] unused_rd;
        one    = row;
        one.op = OP_WRITE;
        for (int a = 0; a < 2 ** VRAM_AW; a++)
        begin
            one.addr = 15'(a);
            cpu_access(one, unused_rd);
        end
        if (row.bank == BANK_CODE)
            fill_word = row.data;
        else
            fill_attr = row.data[7:0];
    endtask

    //////////////////////////////////////////////////
    // Tile fetch checked mid line from the line after vsync falls

    task automatic tile_lines_test();
        tile_fetch_t exp_tile;
        logic [2:0]  row_bits;
        int          line;
        wait_vsync_fall();
        line = VSYNC_START;
        for (int i = 0; i < TILE_LINES; i++)
        begin
            wait_hblank_rise();
            line = (line + 1) % V_TOTAL;
            wait_pixels(H_ACTIVE / 2, "middle of the line");
            row_bits = 3'(line % 8);
            if (fill_word[11])
                row_bits = ~row_bits;                   // vflip mirrors the row
            exp_tile.tile_addr = {fill_word[10:0], row_bits};
            exp_tile.palette   = fill_word[15:12];
            exp_tile.colour    = fill_attr[6:0];
            exp_tile.hflip     = fill_attr[7];
            expect_equal(32'(tile_out), 32'(exp_tile), $sformatf("o_tile_fetch on line %0d", line));
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus table

    task automatic build_table();
        logic [15:0] d1;
        logic [15:0] d2;
        logic [15:0] d3;
        logic [7:0]  d4;
        logic [15:0] w0;
        logic [15:0] w1;
        logic [7:0]  a0;
        d1 = 16'($urandom());
        d2 = 16'($urandom());
        d3 = 16'($urandom());
        d4 = 8'($urandom());
        w0 = 16'($urandom()) & 16'hF7FF;                // Tile word with vflip clear
        w1 = 16'($urandom()) | 16'h0800;                // Tile word with vflip set
        a0 = 8'($urandom());
        // op, bank, addr, data, {uds_n, lds_n}, expected
        stim[0]  = '{OP_WRITE, BANK_CODE, 15'h010, d1, 2'b00, 16'h0};
        stim[1]  = '{OP_READ,  BANK_CODE, 15'h010, 16'h0, 2'b00, d1};
        stim[2]  = '{OP_WRITE, BANK_CODE, 15'h010, d2, 2'b01, 16'h0};     // Upper only
        stim[3]  = '{OP_READ,  BANK_CODE, 15'h010, 16'h0, 2'b00, {d2[15:8], d1[7:0]}};
        stim[4]  = '{OP_WRITE, BANK_CODE, 15'h010, d3, 2'b10, 16'h0};     // Lower only
        stim[5]  = '{OP_READ,  BANK_CODE, 15'h010, 16'h0, 2'b00, {d2[15:8], d3[7:0]}};
        stim[6]  = '{OP_WRITE, BANK_CODE, 15'h7FF, d3, 2'b00, 16'h0};     // Top address
        stim[7]  = '{OP_READ,  BANK_CODE, 15'h7FF, 16'h0, 2'b00, d3};
        stim[8]  = '{OP_WRITE, BANK_ATTR, 15'h123, {d1[15:8], d4}, 2'b00, 16'h0};
        stim[9]  = '{OP_READ,  BANK_ATTR, 15'h123, 16'h0, 2'b00, {8'hFF, d4}};
        stim[10] = '{OP_WRITE, BANK_ATTR, 15'h123, d2, 2'b01, 16'h0};     // No lower strobe
        stim[11] = '{OP_READ,  BANK_ATTR, 15'h123, 16'h0, 2'b00, {8'hFF, d4}};
        stim[12] = '{OP_READ,  BANK_NONE, 15'h010, 16'h0, 2'b00, 16'hFFFF};
        stim[13] = '{OP_FILL,  BANK_CODE, 15'h0, w0, 2'b00, 16'h0};
        stim[14] = '{OP_FILL,  BANK_ATTR, 15'h0, {8'h00, a0}, 2'b00, 16'h0};
        stim[15] = '{OP_TILE,  BANK_NONE, 15'h0, 16'h0, 2'b11, 16'h0};
        stim[16] = '{OP_FILL,  BANK_CODE, 15'h0, w1, 2'b00, 16'h0};
        stim[17] = '{OP_TILE,  BANK_NONE, 15'h0, 16'h0, 2'b11, 16'h0};
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        logic [15:0] rdata;
        rst         = 1'b1;
        cen18_n     = 1'b1;
        cpu_addr    = '0;
        cpu_din     = '0;
        cpu_rw      = 1'b1;
        cpu_uds_n   = 1'b1;
        cpu_lds_n   = 1'b1;
        vcs1_n      = 1'b1;
        vcs2_n      = 1'b1;
        fill_word   = '0;
        fill_attr   = '0;
        error_count = 0;
        void'($urandom(32'ha7ed));
        build_table();

        repeat (RESET_CYCLES - 1) @(negedge clk);
        @(posedge clk);
        // Idle state held by reset
        expect_equal(32'({cen9p_n, cen9n_n, cen6p_n, cen6n_n}), 32'hF, "enables in reset");
        expect_equal(32'(vsync_n), 32'h1, "o_VSYNC_n in reset");
        expect_equal(32'(csync_n), 32'h1, "o_CSYNC_n in reset");
        expect_equal(32'(tile_out), 32'h0, "o_tile_fetch in reset");
        @(negedge clk);
        rst = 1'b0;

        enable_sequence_test();
        frame_timing_test();

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            case (stim[r].op)
                OP_WRITE: cpu_access(stim[r], rdata);
                OP_READ:
                begin
                    cpu_access(stim[r], rdata);
                    expect_equal(32'(rdata), 32'(stim[r].expect_val),
                                 $sformatf("o_CPU_DOUT in row %0d", r));
                end
                OP_FILL:  fill_bank(stim[r]);
                default:  tile_lines_test();
            endcase
        end

        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog/bubsys_video.sv
module bubsys_video
#(
    parameter int H_TOTAL     = bubsys_video_pkg::H_TOTAL,
    parameter int H_ACTIVE    = bubsys_video_pkg::H_ACTIVE,
    parameter int V_TOTAL     = bubsys_video_pkg::V_TOTAL,
    parameter int V_ACTIVE    = bubsys_video_pkg::V_ACTIVE,
    parameter int HSYNC_START = bubsys_video_pkg::HSYNC_START,
    parameter int HSYNC_LEN   = bubsys_video_pkg::HSYNC_LEN,
    parameter int VSYNC_START = bubsys_video_pkg::VSYNC_START,
    parameter int VSYNC_LEN   = bubsys_video_pkg::VSYNC_LEN,
    parameter int VRAM_AW     = bubsys_video_pkg::VRAM_AW
)
(
    input  logic                            i_EMU_MCLK,
    input  logic                            i_rst,
    input  logic                            i_EMU_CLK18MNCEN_n,

    output logic                            o_EMU_CLK9MPCEN_n,
    output logic                            o_EMU_CLK9MNCEN_n,
    output logic                            o_EMU_CLK6MPCEN_n,      // Pixel enable
    output logic                            o_EMU_CLK6MNCEN_n,

    input  logic [14:0]                     i_CPU_ADDR,
    input  logic [15:0]                     i_CPU_DIN,
    output logic [15:0]                     o_CPU_DOUT,
    input  logic                            i_CPU_RW,
    input  logic                            i_CPU_UDS_n,
    input  logic                            i_CPU_LDS_n,

    input  logic                            i_VCS1_n,
    input  logic                            i_VCS2_n,

    output logic                            o_HBLANK_n,
    output logic                            o_VBLANK_n,
    output logic                            o_VSYNC_n,
    output logic                            o_CSYNC_n,

    output bubsys_video_pkg::tile_fetch_t   o_tile_fetch
);

    import bubsys_video_pkg::*;

    cen_t               cen;
    pixel_pos_t         pos;
    video_timing_t      timing;
    cpu_bus_t           cpu_bus;
    logic [VRAM_AW-1:0] vram_addr;
    logic [1:0]         vram1_we;
    logic               vram2_we;
    logic               rdlatch_en;
    logic               tile_latch_en;
    vram_word_t         vram1_dout;
    vram_attr_t         vram2_dout;

    //////////////////////////////////////////////////
    // Input side

    assign cpu_bus = '{addr: i_CPU_ADDR, din: i_CPU_DIN, rw: i_CPU_RW,
                       uds_n: i_CPU_UDS_n, lds_n: i_CPU_LDS_n};

    clock_enable_gen clock_enable_gen_inst
    (
        .i_EMU_MCLK         (i_EMU_MCLK),
        .i_rst              (i_rst),
        .i_EMU_CLK18MNCEN_n (i_EMU_CLK18MNCEN_n),
        .o_cen              (cen)
    );

    video_counter
    #(
        .H_TOTAL        (H_TOTAL),
        .H_ACTIVE       (H_ACTIVE),
        .V_TOTAL        (V_TOTAL),
        .V_ACTIVE       (V_ACTIVE),
        .HSYNC_START    (HSYNC_START),
        .HSYNC_LEN      (HSYNC_LEN),
        .VSYNC_START    (VSYNC_START),
        .VSYNC_LEN      (VSYNC_LEN)
    )
    video_counter_inst
    (
        .i_EMU_MCLK     (i_EMU_MCLK),
        .i_rst          (i_rst),
        .i_cen          (cen),
        .o_pos          (pos),
        .o_timing       (timing),
        .o_csync_n      (o_CSYNC_n)
    );

    //////////////////////////////////////////////////
    // Video RAM and its slot control

    vram_access_ctrl #(.VRAM_AW(VRAM_AW)) vram_access_ctrl_inst
    (
        .i_EMU_MCLK         (i_EMU_MCLK),
        .i_rst              (i_rst),
        .i_cen              (cen),
        .i_pos              (pos),
        .i_cpu              (cpu_bus),
        .i_VCS1_n           (i_VCS1_n),
        .i_VCS2_n           (i_VCS2_n),
        .o_addr             (vram_addr),
        .o_vram1_we         (vram1_we),
        .o_vram2_we         (vram2_we),
        .o_rdlatch_en       (rdlatch_en),
        .o_tile_latch_en    (tile_latch_en)
    );

    vram_bank #(.word_t(vram_word_t), .VRAM_AW(VRAM_AW)) vram1_inst      // Code words
    (
        .i_EMU_MCLK (i_EMU_MCLK),
        .i_addr     (vram_addr),
        .i_din      (vram_word_t'(cpu_bus.din)),
        .i_we       (vram1_we),
        .o_dout     (vram1_dout)
    );

    vram_bank #(.word_t(vram_attr_t), .VRAM_AW(VRAM_AW)) vram2_inst      // Attributes, low lane
    (
        .i_EMU_MCLK (i_EMU_MCLK),
        .i_addr     (vram_addr),
        .i_din      (vram_attr_t'(cpu_bus.din[7:0])),
        .i_we       (vram2_we),
        .o_dout     (vram2_dout)
    );

    //////////////////////////////////////////////////
    // Output side

    tile_fetch tile_fetch_inst
    (
        .i_EMU_MCLK     (i_EMU_MCLK),
        .i_rst          (i_rst),
        .i_cen          (cen),
        .i_latch_en     (tile_latch_en),
        .i_pos          (pos),
        .i_word         (vram1_dout),
        .i_attr         (vram2_dout),
        .o_tile_fetch   (o_tile_fetch)
    );

    cpu_read_mux cpu_read_mux_inst
    (
        .i_EMU_MCLK     (i_EMU_MCLK),
        .i_rst          (i_rst),
        .i_rdlatch_en   (rdlatch_en),
        .i_vram1        (vram1_dout),
        .i_vram2        (vram2_dout),
        .i_VCS1_n       (i_VCS1_n),
        .i_VCS2_n       (i_VCS2_n),
        .o_CPU_DOUT     (o_CPU_DOUT)
    );

    assign o_EMU_CLK9MPCEN_n = cen.cen9mp_n;
    assign o_EMU_CLK9MNCEN_n = cen.cen9mn_n;
    assign o_EMU_CLK6MPCEN_n = cen.cen6mp_n;
    assign o_EMU_CLK6MNCEN_n = cen.cen6mn_n;

    assign o_HBLANK_n = timing.hblank_n;
    assign o_VBLANK_n = timing.vblank_n;
    assign o_VSYNC_n  = timing.vsync_n;

endmodule

//--- verilog/bubsys_video_pkg.sv
package bubsys_video_pkg;

    //////////////////////////////////////////////////
    // Raster geometry, in pixels and lines

    localparam int H_TOTAL     = 384;   // Pixels per line
    localparam int H_ACTIVE    = 256;   // Visible pixels
    localparam int V_TOTAL     = 264;   // Lines per frame
    localparam int V_ACTIVE    = 224;   // Visible lines

    localparam int HSYNC_START = 304;
    localparam int HSYNC_LEN   = 32;
    localparam int VSYNC_START = 240;
    localparam int VSYNC_LEN   = 8;

    // 2k words per bank
    localparam int VRAM_AW     = 11;

    //////////////////////////////////////////////////
    // Bundles

    // All active low, one MCLK wide
    typedef struct packed {
        logic cen9mp_n;
        logic cen9mn_n;
        logic cen6mp_n;                 // Pixel clock enable
        logic cen6mn_n;
    } cen_t;

    typedef struct packed {
        logic [8:0] hcount;
        logic [8:0] vcount;
    } pixel_pos_t;

    typedef struct packed {
        logic hblank_n;
        logic vblank_n;
        logic hsync_n;
        logic vsync_n;
    } video_timing_t;

    // 68000 side, level held by the CPU
    typedef struct packed {
        logic [14:0] addr;              // Word address
        logic [15:0] din;
        logic        rw;                // High for read
        logic        uds_n;
        logic        lds_n;
    } cpu_bus_t;

    // Bank 1 code word
    typedef struct packed {
        logic [3:0]  prio;              // Palette select
        logic        vflip;
        logic [10:0] code;
    } vram_word_t;

    // Bank 2 attribute byte
    typedef struct packed {
        logic       hflip;
        logic [6:0] colour;
    } vram_attr_t;

    typedef struct packed {
        logic [13:0] tile_addr;         // Code, then line in tile
        logic [3:0]  palette;
        logic [6:0]  colour;
        logic        hflip;
    } tile_fetch_t;

endpackage

//--- verilog/clock_enable_gen.sv
module clock_enable_gen
(
    input  logic                        i_EMU_MCLK,
    input  logic                        i_rst,
    input  logic                        i_EMU_CLK18MNCEN_n,     // One MCLK low per 18M tick

    output bubsys_video_pkg::cen_t      o_cen
);

    import bubsys_video_pkg::*;

    logic [2:0] step;           // 18M tick within one 6M period pair
    cen_t       pattern;        // Enable set shown on the next 18M tick

    // Mod-6 step counter, starts on the last step
    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_rst)
        begin
            step    <= 3'd5;
            pattern <= 4'b1111;                         // Nothing enabled
        end
        else if (!i_EMU_CLK18MNCEN_n)
        begin
            step <= (step == 3'd5) ? 3'd0 : step + 3'd1;
            case (step)
                3'd0:    pattern <= 4'b0110;            // 9MP + 6MN
                3'd1:    pattern <= 4'b1001;            // 9MN + 6MP
                3'd2:    pattern <= 4'b0111;            // 9MP
                3'd3:    pattern <= 4'b1010;            // 9MN + 6MN
                3'd4:    pattern <= 4'b0101;            // 9MP + 6MP
                3'd5:    pattern <= 4'b1011;            // 9MN
                default: pattern <= 4'b1111;
            endcase
        end
    end

    // Qualified by the 18M enable itself
    // so each enable is exactly one MCLK long
    assign o_cen = cen_t'(pattern | {4{i_EMU_CLK18MNCEN_n}});

endmodule

//--- verilog/cpu_read_mux.sv
module cpu_read_mux
(
    input  logic                            i_EMU_MCLK,
    input  logic                            i_rst,
    input  logic                            i_rdlatch_en,
    input  bubsys_video_pkg::vram_word_t    i_vram1,
    input  bubsys_video_pkg::vram_attr_t    i_vram2,
    input  logic                            i_VCS1_n,
    input  logic                            i_VCS2_n,

    output logic [15:0]                     o_CPU_DOUT
);

    import bubsys_video_pkg::*;

    vram_word_t rd_word;        // Bank 1 as seen in the CPU slot
    vram_attr_t rd_attr;        // Bank 2 likewise

    // Capture in the CPU read slot, fetch data never reaches the bus
    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_rst)
        begin
            rd_word <= '0;
            rd_attr <= '0;
        end
        else if (i_rdlatch_en)
        begin
            rd_word <= i_vram1;
            rd_attr <= i_vram2;
        end
    end

    //////////////////////////////////////////////////
    // Chip select mux, bus pulled up when nothing drives it

    always_comb
    begin
        case ({i_VCS1_n, i_VCS2_n})
            2'b01:   o_CPU_DOUT = rd_word;
            2'b10:   o_CPU_DOUT = {8'hFF, rd_attr};     // Upper byte floats high
            default: o_CPU_DOUT = 16'hFFFF;
        endcase
    end

endmodule

//--- verilog/tile_fetch.sv
module tile_fetch
(
    input  logic                            i_EMU_MCLK,
    input  logic                            i_rst,
    input  bubsys_video_pkg::cen_t          i_cen,
    input  logic                            i_latch_en,     // Phase 3 window
    input  bubsys_video_pkg::pixel_pos_t    i_pos,
    input  bubsys_video_pkg::vram_word_t    i_word,
    input  bubsys_video_pkg::vram_attr_t    i_attr,

    output bubsys_video_pkg::tile_fetch_t   o_tile_fetch
);

    import bubsys_video_pkg::*;

    logic [2:0]  line;          // Row inside the 8x8 tile
    tile_fetch_t next_tile;

    // Vertical flip mirrors the row
    assign line = i_pos.vcount[2:0] ^ {3{i_word.vflip}};

    always_comb
    begin
        next_tile.tile_addr = {i_word.code, line};
        next_tile.palette   = i_word.prio;
        next_tile.colour    = i_attr.colour;
        next_tile.hflip     = i_attr.hflip;
    end

    //////////////////////////////////////////////////
    // One latch per cell, closing phase 3

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_rst)
        begin
            o_tile_fetch <= '0;
        end
        else if (!i_cen.cen6mp_n && i_latch_en)
        begin
            o_tile_fetch <= next_tile;          // Held for the whole cell
        end
    end

endmodule

//--- verilog/video_counter.sv
module video_counter
#(
    parameter int H_TOTAL     = bubsys_video_pkg::H_TOTAL,
    parameter int H_ACTIVE    = bubsys_video_pkg::H_ACTIVE,
    parameter int V_TOTAL     = bubsys_video_pkg::V_TOTAL,
    parameter int V_ACTIVE    = bubsys_video_pkg::V_ACTIVE,
    parameter int HSYNC_START = bubsys_video_pkg::HSYNC_START,
    parameter int HSYNC_LEN   = bubsys_video_pkg::HSYNC_LEN,
    parameter int VSYNC_START = bubsys_video_pkg::VSYNC_START,
    parameter int VSYNC_LEN   = bubsys_video_pkg::VSYNC_LEN
)
(
    input  logic                                i_EMU_MCLK,
    input  logic                                i_rst,
    input  bubsys_video_pkg::cen_t              i_cen,

    output bubsys_video_pkg::pixel_pos_t        o_pos,
    output bubsys_video_pkg::video_timing_t     o_timing,
    output logic                                o_csync_n
);

    import bubsys_video_pkg::*;

    pixel_pos_t pos_next;       // Position after this pixel
    logic       hsync_win;
    logic       vsync_win;

    // Counter wrap
    always_comb
    begin
        pos_next = o_pos;
        if (o_pos.hcount == 9'(H_TOTAL - 1))
        begin
            pos_next.hcount = '0;
            if (o_pos.vcount == 9'(V_TOTAL - 1))
            begin
                pos_next.vcount = '0;                   // New frame
            end
            else
            begin
                pos_next.vcount = o_pos.vcount + 9'd1;
            end
        end
        else
        begin
            pos_next.hcount = o_pos.hcount + 9'd1;
        end
    end

    // Sync windows on the next position, so flags line up with the counters
    assign hsync_win = (pos_next.hcount >= 9'(HSYNC_START)) &&
                       (pos_next.hcount <  9'(HSYNC_START + HSYNC_LEN));
    assign vsync_win = (pos_next.vcount >= 9'(VSYNC_START)) &&
                       (pos_next.vcount <  9'(VSYNC_START + VSYNC_LEN));

    //////////////////////////////////////////////////
    // Counters and registered blank/sync, one step per pixel

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_rst)
        begin
            o_pos    <= '0;
            o_timing <= 4'b1111;                        // Line 0 pixel 0 is visible
        end
        else if (!i_cen.cen6mp_n)
        begin
            o_pos             <= pos_next;
            o_timing.hblank_n <= pos_next.hcount < 9'(H_ACTIVE);
            o_timing.vblank_n <= pos_next.vcount < 9'(V_ACTIVE);
            o_timing.hsync_n  <= ~hsync_win;
            o_timing.vsync_n  <= ~vsync_win;
        end
    end

    // Composite sync, low on either
    assign o_csync_n = o_timing.hsync_n & o_timing.vsync_n;

endmodule

//--- verilog/vram_access_ctrl.sv
module vram_access_ctrl
#(
    parameter int VRAM_AW = bubsys_video_pkg::VRAM_AW
)
(
    input  logic                            i_EMU_MCLK,
    input  logic                            i_rst,
    input  bubsys_video_pkg::cen_t          i_cen,
    input  bubsys_video_pkg::pixel_pos_t    i_pos,
    input  bubsys_video_pkg::cpu_bus_t      i_cpu,
    input  logic                            i_VCS1_n,       // Code bank select
    input  logic                            i_VCS2_n,       // Attribute bank select

    output logic [VRAM_AW-1:0]              o_addr,
    output logic [1:0]                      o_vram1_we,     // Upper, lower
    output logic                            o_vram2_we,
    output logic                            o_rdlatch_en,
    output logic                            o_tile_latch_en
);

    logic [2:0] phase;          // Pixel within the cell
    logic       cpu_slot;       // Phases 0,1,4,5
    logic       wr_slot;        // Phases 0,4
    logic       wr_strobe;
    logic [2:0] wr_req;         // {vram1 upper, vram1 lower, vram2}

    assign phase    = i_pos.hcount[2:0];
    assign cpu_slot = ~phase[1];
    assign wr_slot  = (phase[1:0] == 2'b00);

    // CPU address in its slots, otherwise the cell under the beam
    assign o_addr = cpu_slot ? i_cpu.addr[VRAM_AW-1:0]
                             : VRAM_AW'({i_pos.vcount[7:3], i_pos.hcount[8:3]});

    //////////////////////////////////////////////////
    // Write request, sampled mid-pixel on 6MN of the write slot

    always_ff @(posedge i_EMU_MCLK)
    begin
        if (i_rst)
        begin
            wr_req <= '0;
        end
        else if (!i_cen.cen6mn_n && wr_slot)
        begin
            wr_req[2] <= ~i_VCS1_n & ~i_cpu.rw & ~i_cpu.uds_n;
            wr_req[1] <= ~i_VCS1_n & ~i_cpu.rw & ~i_cpu.lds_n;
            wr_req[0] <= ~i_VCS2_n & ~i_cpu.rw & ~i_cpu.lds_n;     // Byte wide bank
        end
    end

    // RAM takes the write on the pixel edge closing phase 0/4
    assign wr_strobe  = ~i_cen.cen6mp_n & wr_slot;
    assign o_vram1_we = wr_req[2:1] & {2{wr_strobe}};
    assign o_vram2_we = wr_req[0] & wr_strobe;

    assign o_rdlatch_en    = ~i_cen.cen6mp_n & (phase[1:0] == 2'b01);  // End of phase 1/5
    assign o_tile_latch_en = (phase == 3'd3);      // Window only, edged by 6MP downstream

endmodule

//--- verilog/vram_bank.sv
module vram_bank
#(
    parameter type word_t  = bubsys_video_pkg::vram_word_t,
    parameter int  VRAM_AW = bubsys_video_pkg::VRAM_AW
)
(
    input  logic                            i_EMU_MCLK,
    input  logic [VRAM_AW-1:0]              i_addr,
    input  word_t                           i_din,
    input  logic [$bits(word_t)/8-1:0]      i_we,       // One per byte lane

    output word_t                           o_dout
);

    localparam int NBYTES = $bits(word_t) / 8;
    localparam int DEPTH  = 2 ** VRAM_AW;

    word_t mem [DEPTH];

    //////////////////////////////////////////////////
    // Byte lanes written independently

    always_ff @(posedge i_EMU_MCLK)
    begin
        for (int b = 0; b < NBYTES; b++)
        begin
            if (i_we[b])
            begin
                mem[i_addr][b*8 +: 8] <= i_din[b*8 +: 8];
            end
        end
    end

    // Registered read
    // CPU and fetch slots hold the address for several clocks
    always_ff @(posedge i_EMU_MCLK)
    begin
        o_dout <= mem[i_addr];
    end

endmodule
